// File: design/beat_fifo.sv
`timescale 1ns/10ps

module beat_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_wr,
    input  T     i_wr_data,
    output logic o_not_full,

    output T     o_rd_data,
    output logic o_rd_valid,
    input  logic i_rd_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign o_not_full = (count != (AW+1)'(DEPTH));
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];

    assign wr_en = i_wr && o_not_full;
    assign rd_en = o_rd_valid && i_rd_ready;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Simultaneous write and read leave the count alone
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/reply_header_builder.sv
`timescale 1ns/10ps

module reply_header_builder (
    input  logic                         i_clk,
    input  logic                         i_rst,

    input  logic                         i_capture,
    input  udp_echo_pkg::udp_rx_hdr_t    i_capture_hdr,
    output logic                         o_free,

    output udp_echo_pkg::udp_reply_hdr_t o_tx_hdr,
    output logic                         o_tx_hdr_valid,
    input  logic                         i_tx_hdr_ready
);

    udp_echo_pkg::udp_reply_hdr_t hdr_q;
    logic                         valid_q;

    assign o_tx_hdr       = hdr_q;
    assign o_tx_hdr_valid = valid_q;
    assign o_free         = !valid_q;

    // Held until the stack takes it
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (i_capture) begin
            valid_q <= 1'b1;
        end else if (valid_q && i_tx_hdr_ready) begin
            valid_q <= 1'b0;
        end
    end

    // Reply goes back to whoever sent the frame
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            hdr_q.dest_ip <= i_capture_hdr.source_ip;
            hdr_q.length  <= i_capture_hdr.length;
        end
    end

endmodule

// File: design/status_display.sv
`timescale 1ns/10ps

module status_display (
    input  logic                               i_clk,
    input  logic                               i_rst,

    // Reply payload transfer
    input  udp_echo_pkg::payload_beat_t        i_tx_beat,
    input  logic                               i_tx_beat_fire,

    // Reply header as presented to the stack
    input  udp_echo_pkg::udp_reply_hdr_t       i_tx_hdr,
    input  logic                               i_tx_hdr_valid,

    output logic [udp_echo_pkg::LED_WIDTH-1:0] o_led,
    output logic [udp_echo_pkg::HEX_DIGITS-1:0][udp_echo_pkg::SEG_WIDTH-1:0] o_hex
);

    logic        mid_frame;
    logic [7:0]  first_byte;
    logic [31:0] ip_q;

    // First byte of each echoed frame
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mid_frame  <= 1'b0;
            first_byte <= '0;
        end else if (i_tx_beat_fire) begin
            if (!mid_frame) begin
                first_byte <= i_tx_beat.data;
            end
            mid_frame <= !i_tx_beat.last;
        end
    end

    assign o_led = udp_echo_pkg::LED_WIDTH'(first_byte);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ip_q <= '0;
        end else if (i_tx_hdr_valid) begin
            ip_q <= i_tx_hdr.dest_ip;
        end
    end

    // Digit 0 shows the lowest nibble, segments are active low
    always_comb begin
        for (int i = 0; i < udp_echo_pkg::HEX_DIGITS; i++) begin
            o_hex[i] = ~udp_echo_pkg::SEG_TABLE[ip_q[i*4 +: 4]];
        end
    end

endmodule

// File: design/udp_echo_pkg.sv
package udp_echo_pkg;

    // Echo service port and fixed reply fields
    localparam logic [15:0] ECHO_PORT  = 16'd1234;
    localparam logic [15:0] REPLY_PORT = 16'd8080;
    localparam logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd50, 8'd168};
    localparam logic [7:0]  REPLY_TTL  = 8'd64;

    localparam int PAYLOAD_FIFO_DEPTH = 64;

    // Board display sizes
    localparam int LED_WIDTH  = 18;
    localparam int HEX_DIGITS = 8;
    localparam int SEG_WIDTH  = 7;

    // Parsed header of a received UDP frame
    typedef struct packed {
        logic [31:0] source_ip;
        logic [15:0] dest_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // Variable part of the reply header
    typedef struct packed {
        logic [31:0] dest_ip;
        logic [15:0] length;
    } udp_reply_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } payload_beat_t;

    // Segment patterns, bit 0 is segment a, bit 6 is segment g
    localparam logic [SEG_WIDTH-1:0] SEG_TABLE [16] = '{
        7'h3f,
        7'h06,
        7'h5b,
        7'h4f,
        7'h66,
        7'h6d,
        7'h7d,
        7'h07,
        7'h7f,
        7'h6f,
        7'h77,
        7'h7c,
        7'h39,
        7'h5e,
        7'h79,
        7'h71
    };

endpackage

// File: design/udp_echo_top.sv
`timescale 1ns/10ps

module udp_echo_top (
    input  logic                               i_clk,
    input  logic                               i_rst,

    // Received UDP header and payload from the stack
    input  udp_echo_pkg::udp_rx_hdr_t          i_rx_hdr,
    input  logic                               i_rx_hdr_valid,
    output logic                               o_rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t        i_rx_pay,
    input  logic                               i_rx_pay_valid,
    output logic                               o_rx_pay_ready,

    // Reply header and payload to the stack
    output udp_echo_pkg::udp_reply_hdr_t       o_tx_hdr,
    output logic                               o_tx_hdr_valid,
    input  logic                               i_tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t        o_tx_pay,
    output logic                               o_tx_pay_valid,
    input  logic                               i_tx_pay_ready,

    output logic [udp_echo_pkg::LED_WIDTH-1:0] o_led,
    output logic [udp_echo_pkg::HEX_DIGITS-1:0][udp_echo_pkg::SEG_WIDTH-1:0] o_hex
);

    logic                        capture;
    udp_echo_pkg::udp_rx_hdr_t   capture_hdr;
    logic                        builder_free;
    logic                        fifo_wr;
    udp_echo_pkg::payload_beat_t fifo_beat;
    logic                        fifo_not_full;
    logic                        tx_pay_fire;

    assign tx_pay_fire = o_tx_pay_valid && i_tx_pay_ready;

    udp_port_filter u_udp_port_filter (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_rx_hdr        (i_rx_hdr),
        .i_rx_hdr_valid  (i_rx_hdr_valid),
        .o_rx_hdr_ready  (o_rx_hdr_ready),
        .i_rx_pay        (i_rx_pay),
        .i_rx_pay_valid  (i_rx_pay_valid),
        .o_rx_pay_ready  (o_rx_pay_ready),
        .o_capture       (capture),
        .o_capture_hdr   (capture_hdr),
        .i_builder_free  (builder_free),
        .o_fifo_wr       (fifo_wr),
        .o_fifo_beat     (fifo_beat),
        .i_fifo_not_full (fifo_not_full)
    );

    reply_header_builder u_reply_header_builder (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_capture      (capture),
        .i_capture_hdr  (capture_hdr),
        .o_free         (builder_free),
        .o_tx_hdr       (o_tx_hdr),
        .o_tx_hdr_valid (o_tx_hdr_valid),
        .i_tx_hdr_ready (i_tx_hdr_ready)
    );

    // Echoed payload goes straight out of the FIFO
    beat_fifo #(
        .T     (udp_echo_pkg::payload_beat_t),
        .DEPTH (udp_echo_pkg::PAYLOAD_FIFO_DEPTH)
    ) u_beat_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr       (fifo_wr),
        .i_wr_data  (fifo_beat),
        .o_not_full (fifo_not_full),
        .o_rd_data  (o_tx_pay),
        .o_rd_valid (o_tx_pay_valid),
        .i_rd_ready (i_tx_pay_ready)
    );

    status_display u_status_display (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_tx_beat      (o_tx_pay),
        .i_tx_beat_fire (tx_pay_fire),
        .i_tx_hdr       (o_tx_hdr),
        .i_tx_hdr_valid (o_tx_hdr_valid),
        .o_led          (o_led),
        .o_hex          (o_hex)
    );

endmodule

// File: design/udp_port_filter.sv
`timescale 1ns/10ps

module udp_port_filter (
    input  logic                        i_clk,
    input  logic                        i_rst,

    input  udp_echo_pkg::udp_rx_hdr_t   i_rx_hdr,
    input  logic                        i_rx_hdr_valid,
    output logic                        o_rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t i_rx_pay,
    input  logic                        i_rx_pay_valid,
    output logic                        o_rx_pay_ready,

    // Header capture into the reply builder
    output logic                        o_capture,
    output udp_echo_pkg::udp_rx_hdr_t   o_capture_hdr,
    input  logic                        i_builder_free,

    // Payload into the echo FIFO
    output logic                        o_fifo_wr,
    output udp_echo_pkg::payload_beat_t o_fifo_beat,
    input  logic                        i_fifo_not_full
);

    typedef enum logic {
        AWAIT_HDR,
        IN_FRAME
    } state_t;

    state_t state;
    logic   pass;
    logic   is_echo;
    logic   hdr_fire;
    logic   pay_fire;

    assign is_echo = (i_rx_hdr.dest_port == udp_echo_pkg::ECHO_PORT);

    // An echo header must wait until the previous reply header is gone
    assign o_rx_hdr_ready = (state == AWAIT_HDR) && (!is_echo || i_builder_free);
    assign hdr_fire       = i_rx_hdr_valid && o_rx_hdr_ready;

    assign o_capture     = hdr_fire && is_echo;
    assign o_capture_hdr = i_rx_hdr;

    // Dropped frames are sunk at full rate
    assign o_rx_pay_ready = (state == IN_FRAME) && (!pass || i_fifo_not_full);
    assign pay_fire       = i_rx_pay_valid && o_rx_pay_ready;

    assign o_fifo_wr   = pay_fire && pass;
    assign o_fifo_beat = i_rx_pay;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= AWAIT_HDR;
            pass  <= 1'b0;
        end else begin
            case (state)
                AWAIT_HDR: begin
                    if (hdr_fire) begin
                        state <= IN_FRAME;
                        pass  <= is_echo;
                    end
                end
                IN_FRAME: begin
                    if (pay_fire && i_rx_pay.last) begin
                        state <= AWAIT_HDR;
                    end
                end
                default: begin
                    state <= AWAIT_HDR;
                end
            endcase
        end
    end

endmodule

// File: files.f
design/udp_echo_pkg.sv
design/beat_fifo.sv
design/udp_port_filter.sv
design/reply_header_builder.sv
design/status_display.sv
design/udp_echo_top.sv
test/tb_udp_echo.sv

// File: test/tb_udp_echo.sv
`timescale 1ns/10ps

module tb_udp_echo;

    localparam int          NREC      = 20;
    localparam int          REC_BYTES = 24;
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam int          CLK_NS    = 4;
    // Forty cycles allowed per record
    localparam int          LIMIT_NS  = NREC * 40 * CLK_NS;

    logic                          i_clk;
    logic                          i_rst;
    udp_echo_pkg::udp_rx_hdr_t     i_rx_hdr;
    logic                          i_rx_hdr_valid;
    logic                          o_rx_hdr_ready;
    udp_echo_pkg::payload_beat_t   i_rx_pay;
    logic                          i_rx_pay_valid;
    logic                          o_rx_pay_ready;
    udp_echo_pkg::udp_reply_hdr_t  o_tx_hdr;
    logic                          o_tx_hdr_valid;
    logic                          i_tx_hdr_ready;
    udp_echo_pkg::payload_beat_t   o_tx_pay;
    logic                          o_tx_pay_valid;
    logic                          i_tx_pay_ready;
    logic [udp_echo_pkg::LED_WIDTH-1:0] o_led;
    logic [udp_echo_pkg::HEX_DIGITS-1:0][udp_echo_pkg::SEG_WIDTH-1:0] o_hex;

    logic [7:0]  tdata [NREC*REC_BYTES];
    logic [47:0] exp_hdr_q [$];
    logic [8:0]  exp_pay_q [$];
    logic        stall;
    logic        stall_done;

    udp_echo_top u_udp_echo_top (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rx_hdr       (i_rx_hdr),
        .i_rx_hdr_valid (i_rx_hdr_valid),
        .o_rx_hdr_ready (o_rx_hdr_ready),
        .i_rx_pay       (i_rx_pay),
        .i_rx_pay_valid (i_rx_pay_valid),
        .o_rx_pay_ready (o_rx_pay_ready),
        .o_tx_hdr       (o_tx_hdr),
        .o_tx_hdr_valid (o_tx_hdr_valid),
        .i_tx_hdr_ready (i_tx_hdr_ready),
        .o_tx_pay       (o_tx_pay),
        .o_tx_pay_valid (o_tx_pay_valid),
        .i_tx_pay_ready (i_tx_pay_ready),
        .o_led          (o_led),
        .o_hex          (o_hex)
    );

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // Active-high segments a..g in bits 0..6
    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: seg_pattern = 7'h3f;
            4'h1: seg_pattern = 7'h06;
            4'h2: seg_pattern = 7'h5b;
            4'h3: seg_pattern = 7'h4f;
            4'h4: seg_pattern = 7'h66;
            4'h5: seg_pattern = 7'h6d;
            4'h6: seg_pattern = 7'h7d;
            4'h7: seg_pattern = 7'h07;
            4'h8: seg_pattern = 7'h7f;
            4'h9: seg_pattern = 7'h6f;
            4'ha: seg_pattern = 7'h77;
            4'hb: seg_pattern = 7'h7c;
            4'hc: seg_pattern = 7'h39;
            4'hd: seg_pattern = 7'h5e;
            4'he: seg_pattern = 7'h79;
            default: seg_pattern = 7'h71;
        endcase
    endfunction

    function automatic logic [55:0] hex_expected(input logic [31:0] ip);
        logic [55:0] pat;
        int          i;
        for (i = 0; i < 8; i++) begin
            pat[i*7 +: 7] = ~seg_pattern(ip[i*4 +: 4]);
        end
        return pat;
    endfunction

    task automatic send_record(input int r);
        int          base;
        int          n;
        int          k;
        logic [31:0] ip;
        logic [15:0] port;
        logic [7:0]  flags;
        base  = r * REC_BYTES;
        ip    = {tdata[base], tdata[base+1], tdata[base+2], tdata[base+3]};
        port  = {tdata[base+4], tdata[base+5]};
        n     = tdata[base+6];
        flags = tdata[base+7];
        if (n < 1 || n > 16) begin
            abort_run($sformatf("Testdata record %0d has a bad payload count", r));
        end
        // Hold reply payload from the first record of the stalled run
        if (flags[0] && !stall && !stall_done) begin
            @(posedge i_clk);
            stall = 1'b1;
            @(negedge i_clk);
        end
        if (port == ECHO_PORT) begin
            exp_hdr_q.push_back({ip, 16'(n + 8)});
            for (k = 0; k < n; k++) begin
                exp_pay_q.push_back({tdata[base+8+k], k == n - 1});
            end
        end
        i_rx_hdr       = {ip, port, 16'(n + 8)};
        i_rx_hdr_valid = 1'b1;
        @(posedge i_clk);
        while (!o_rx_hdr_ready) @(posedge i_clk);
        @(negedge i_clk);
        i_rx_hdr_valid = 1'b0;
        for (k = 0; k < n; k++) begin
            i_rx_pay       = {tdata[base+8+k], k == n - 1};
            i_rx_pay_valid = 1'b1;
            @(posedge i_clk);
            while (!o_rx_pay_ready) @(posedge i_clk);
            @(negedge i_clk);
        end
        i_rx_pay_valid = 1'b0;
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    initial begin : watchdog
        #(LIMIT_NS);
        abort_run($sformatf("Run timed out after %0d ns with frames still pending", LIMIT_NS));
    end

    // Reply-side ready is random once out of reset
    initial begin : tx_ready_drive
        void'($urandom(90639));
        i_tx_hdr_ready = 1'b0;
        i_tx_pay_ready = 1'b0;
        wait (!i_rst);
        forever begin
            @(negedge i_clk);
            i_tx_hdr_ready = ($urandom % 4) != 0;
            i_tx_pay_ready = stall ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    initial begin : tx_monitor
        logic [47:0] exp_hdr;
        logic [8:0]  exp_beat;
        logic        hdr_seen;
        logic        last_seen;
        logic        mid;
        logic [7:0]  first_byte;
        logic [31:0] shown_ip;
        mid = 1'b0;
        first_byte = '0;
        shown_ip = '0;
        wait (!i_rst);
        forever begin
            @(posedge i_clk);
            hdr_seen  = 1'b0;
            last_seen = 1'b0;
            // Full FIFO ends the stall so the reply payload drains
            if (stall && i_rx_pay_valid && !o_rx_pay_ready) begin
                stall      = 1'b0;
                stall_done = 1'b1;
            end
            if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    abort_run("Reply header sent with no echoed frame pending");
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check("reply_header", exp_hdr, o_tx_hdr);
                    shown_ip = exp_hdr[47:16];
                    hdr_seen = 1'b1;
                end
            end
            if (o_tx_pay_valid && i_tx_pay_ready) begin
                if (exp_pay_q.size() == 0) begin
                    abort_run("Reply payload beat sent with no echoed byte pending");
                end else begin
                    exp_beat = exp_pay_q.pop_front();
                    check("reply_payload", exp_beat, o_tx_pay);
                    if (!mid) begin
                        first_byte = exp_beat[8:1];
                    end
                    mid       = !exp_beat[0];
                    last_seen = exp_beat[0];
                end
            end
            if (hdr_seen || last_seen) begin
                @(negedge i_clk);
                if (hdr_seen) begin
                    check("hex_reply_ip", hex_expected(shown_ip), o_hex);
                end
                if (last_seen) begin
                    check("led_first_byte", {10'b0, first_byte}, o_led);
                end
            end
        end
    end

    initial begin : main
        int r;
        i_rst          = 1'b1;
        i_rx_hdr       = '0;
        i_rx_hdr_valid = 1'b0;
        i_rx_pay       = '0;
        i_rx_pay_valid = 1'b0;
        stall          = 1'b0;
        stall_done     = 1'b0;
        $readmemh("test/udp_echo_testdata.hex", tdata);
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        check("reset_tx_hdr_valid", 64'd0, o_tx_hdr_valid);
        check("reset_tx_pay_valid", 64'd0, o_tx_pay_valid);
        check("reset_rx_pay_ready", 64'd0, o_rx_pay_ready);
        check("reset_rx_hdr_ready", 64'd1, o_rx_hdr_ready);
        check("reset_led", 64'd0, o_led);
        check("reset_hex", hex_expected(32'd0), o_hex);
        for (r = 0; r < NREC; r++) begin
            send_record(r);
        end
        // A stall that never saw the FIFO fill still has to drain
        @(posedge i_clk);
        stall = 1'b0;
        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0) @(posedge i_clk);
        // Quiet period to catch stray replies
        repeat (20) @(negedge i_clk);
        check("fifo_backpressure_seen", 64'd1, stall_done);
        check("idle_tx_hdr_valid", 64'd0, o_tx_hdr_valid);
        check("idle_tx_pay_valid", 64'd0, o_tx_pay_valid);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: test/udp_echo_testdata.hex
// One frame per line: source IP (4 bytes), destination port (2), payload count (1),
// flags (1, bit 0 starts the stalled run), then 16 payload bytes with unused ones zero
c0 a8 32 0a 04 d2 04 00 de ad be ef 00 00 00 00 00 00 00 00 00 00 00 00
0a 00 00 05 00 35 05 00 01 02 03 04 05 00 00 00 00 00 00 00 00 00 00 00
ac 10 02 03 04 d2 01 00 5a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
c0 a8 32 64 04 d2 10 00 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
0a 01 01 01 1f 90 03 00 77 88 99 00 00 00 00 00 00 00 00 00 00 00 00 00
fe dc ba 98 04 d2 07 00 10 20 30 40 50 60 70 00 00 00 00 00 00 00 00 00
01 23 45 67 04 d2 10 01 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
89 ab cd ef 04 d2 10 01 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
c0 a8 00 01 04 d2 10 01 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
0a 0b 0c 0d 04 d2 10 01 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
7f 00 00 01 04 d2 10 01 e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
c0 a8 32 a8 04 d2 10 01 f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff
64 40 20 10 04 d2 04 01 12 34 56 78 00 00 00 00 00 00 00 00 00 00 00 00
0a 00 00 06 04 d3 02 00 ee ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0a 00 00 07 04 d2 02 00 3c c3 00 00 00 00 00 00 00 00 00 00 00 00 00 00
b1 b2 b3 b4 04 d2 09 00 09 08 07 06 05 04 03 02 01 00 00 00 00 00 00 00
0a 00 00 08 00 00 10 00 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61 62 63 64
11 22 33 44 04 d2 05 00 6b 6c 6d 6e 6f 00 00 00 00 00 00 00 00 00 00 00
ee ee 00 99 04 d2 0c 00 80 81 82 83 84 85 86 87 88 89 8a 8b 00 00 00 00
5e 5e 5e 5e 04 d2 03 00 00 ff 01 00 00 00 00 00 00 00 00 00 00 00 00 00
